// ==== pmu_lite.f ====
rtl/pmu_pkg.sv
rtl/pmu_apb_regs.sv
rtl/pmu_event_timer.sv
rtl/pmu_wake_ctrl.sv
rtl/pmu_mode_fsm.sv
rtl/pmu_pwr_seq.sv
rtl/pmu_top.sv
test/pmu_pwr_props.sv
test/pmu_tb.sv

// ==== test/pmu_tb.sv ====
// pmu_lite testbench
// register readback, light sleep wakeups, deep sleep entry and exit
// with the power sequence compared against a reference model

module pmu_tb;
  import pmu_pkg::*;

  localparam int          CLK_PERIOD = 40;
  localparam logic [31:0] SEED       = 32'h8baab8cf;

  logic              pmu_clk;
  logic              pad_cpu_rst_b;
  apb_req_t          apb;
  logic [APB_DW-1:0] prdata;
  logic [1:0]        lpmd_b;
  logic              intraw_vld;
  logic              gate_en0;
  logic              gate_en1;
  pwr_ctl_t          pwr;

  int                errors       = 0;
  int                pwr_changes  = 0;
  int                limit_cycles = 0;
  logic [31:0]       load_val;

  pmu_top i_dut (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_apb         (apb),
    .o_prdata      (prdata),
    .i_lpmd_b      (lpmd_b),
    .i_intraw_vld  (intraw_vld),
    .o_gate_en0    (gate_en0),
    .o_gate_en1    (gate_en1),
    .o_pwr         (pwr)
  );

  initial
  begin
    pmu_clk = 1'b0;
    forever #(CLK_PERIOD / 2) pmu_clk = ~pmu_clk;
  end

  //--------------------------------------------------
  // helpers
  //--------------------------------------------------
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
    @(posedge pmu_clk);
    apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge pmu_clk);
    apb.penable <= 1'b1;
    @(posedge pmu_clk);
    apb <= '0;
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data);
    @(posedge pmu_clk);
    apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    @(posedge pmu_clk);
    apb.penable <= 1'b1;
    @(negedge pmu_clk);
    data = prdata;
    @(posedge pmu_clk);
    apb <= '0;
  endtask

  task automatic pulse_irq();
    @(posedge pmu_clk);
    intraw_vld <= 1'b1;
    @(posedge pmu_clk);
    intraw_vld <= 1'b0;
  endtask

  task automatic idle_gap();
    repeat ($urandom_range(4, 1)) @(posedge pmu_clk);
  endtask

  // expected controls after a number of steps of entry or exit
  function automatic pwr_ctl_t pwr_expect(input logic exit_phase, input int steps);
    pwr_ctl_t p;
    if (!exit_phase)
    begin
      p.pwr_on  = (steps < 4);
      p.iso_in  = (steps >= 1);
      p.iso_out = (steps >= 1);
      p.save    = (steps == 2);
      p.restore = 1'b0;
    end
    else
    begin
      p.pwr_on  = (steps >= 1);
      p.iso_in  = (steps < 4);
      p.iso_out = (steps < 4);
      p.save    = 1'b0;
      p.restore = (steps == 2);
    end
    return p;
  endfunction

  //--------------------------------------------------
  // power sequence monitor
  //--------------------------------------------------
  initial
  begin : pwr_monitor
    pwr_ctl_t last;
    logic     exit_phase;
    int       steps;
    exit_phase = 1'b0;
    steps      = 0;
    wait (pad_cpu_rst_b === 1'b1);
    last = pwr;
    forever
    begin
      @(negedge pmu_clk);
      if (pwr !== last)
      begin
        steps++;
        pwr_changes++;
        check("o_pwr", {27'b0, pwr}, {27'b0, pwr_expect(exit_phase, steps)});
        last = pwr;
        // four changes per sequence, then the other direction
        if (steps == 4)
        begin
          exit_phase = !exit_phase;
          steps      = 0;
        end
      end
    end
  end

  initial
  begin : watchdog
    wait (limit_cycles > 0);
    #(limit_cycles * CLK_PERIOD);
    $display("timeout: run did not complete within %0d cycles", limit_cycles);
    $display("Finished with errors");
    $finish;
  end

  //--------------------------------------------------
  // stimulus
  //--------------------------------------------------
  initial
  begin : main_seq
    logic [31:0] rd;
    int          n;
    logic        seen;
    apb           = '0;
    lpmd_b        = LPMD_RUN;
    intraw_vld    = 1'b0;
    pad_cpu_rst_b = 1'b0;
    void'($urandom(SEED));
    load_val     = $urandom_range(40, 4);
    limit_cycles = 4 * (2 * STEP_OFF + load_val) + 400;
    repeat (2) @(posedge pmu_clk);
    pad_cpu_rst_b <= 1'b1;

    // reset values and readback
    @(negedge pmu_clk);
    check("o_pwr", {27'b0, pwr}, {27'b0, pwr_expect(1'b0, 0)});
    check("o_gate_en0", gate_en0, 0);
    check("o_gate_en1", gate_en1, 0);
    check("o_prdata", prdata, 0);
    apb_write(ADDR_CTRL, 32'ha5a5_a5a5);
    apb_read(ADDR_CTRL, rd);
    check("o_prdata ctrl", rd, 32'h5);
    apb_write(ADDR_MODE, 32'h1234_5661);
    apb_read(ADDR_MODE, rd);
    check("o_prdata mode", rd, 32'h1234_5661);
    apb_read(12'h00c, rd);
    check("o_prdata unknown", rd, 0);

    // light sleep, slow clock, timer wakeup
    idle_gap();
    apb_write(ADDR_LOAD, load_val);
    apb_read(ADDR_LOAD, rd);
    check("o_prdata load", rd, load_val);
    apb_write(ADDR_MODE, 32'h2);
    apb_write(ADDR_CTRL, 32'ha);
    idle_gap();
    @(posedge pmu_clk);
    lpmd_b <= 2'b00;
    n    = 0;
    seen = 1'b0;
    while (!(seen && !gate_en0) && n <= load_val + 8)
    begin
      @(negedge pmu_clk);
      n++;
      if (gate_en0)
        seen = 1'b1;
    end
    if (!seen || gate_en0 !== 1'b0)
    begin
      errors++;
      $display("light sleep with slow clock was not left by the timer event in time");
    end
    @(posedge pmu_clk);
    lpmd_b <= LPMD_RUN;

    // light sleep, clock off, interrupt wakeup
    idle_gap();
    apb_write(ADDR_CTRL, 32'h0);
    apb_write(ADDR_MODE, 32'h4);
    @(posedge pmu_clk);
    lpmd_b <= 2'b00;
    repeat (3) @(negedge pmu_clk);
    check("o_gate_en1", gate_en1, 1);
    pulse_irq();
    repeat (3) @(negedge pmu_clk);
    check("o_gate_en1", gate_en1, 1);
    apb_write(ADDR_CTRL, 32'h1);
    pulse_irq();
    n = 0;
    while (gate_en1 !== 1'b0 && n < 4)
    begin
      @(negedge pmu_clk);
      n++;
    end
    check("o_gate_en1", gate_en1, 0);
    @(posedge pmu_clk);
    lpmd_b <= LPMD_RUN;

    // deep sleep entry
    idle_gap();
    apb_write(ADDR_MODE, 32'h8);
    @(posedge pmu_clk);
    lpmd_b <= 2'b00;
    repeat (3) @(negedge pmu_clk);
    check("o_gate_en1", gate_en1, 1);
    n = 0;
    while (pwr.pwr_on !== 1'b0 && n < STEP_OFF + 16)
    begin
      @(negedge pmu_clk);
      n++;
    end
    if (pwr.pwr_on !== 1'b0)
    begin
      errors++;
      $display("deep sleep entry did not switch power off in time");
    end
    apb_write(ADDR_MODE, 32'h2);
    apb_read(ADDR_MODE, rd);
    check("o_prdata mode", rd, 32'h8);
    check("o_pwr change count", pwr_changes, 4);

    // deep sleep exit by interrupt
    idle_gap();
    pulse_irq();
    @(posedge pmu_clk);
    lpmd_b <= LPMD_RUN;
    n = 0;
    while (pwr.iso_in !== 1'b0 && n < STEP_OFF + 16)
    begin
      @(negedge pmu_clk);
      n++;
    end
    check("o_gate_en1", gate_en1, 0);
    // mode writes are accepted again once back in normal
    n  = 0;
    rd = '0;
    while (rd !== 32'h1 && n < 12)
    begin
      apb_write(ADDR_MODE, 32'h1);
      apb_read(ADDR_MODE, rd);
      n++;
    end
    check("o_prdata mode", rd, 32'h1);
    repeat (4) @(negedge pmu_clk);
    check("o_pwr change count", pwr_changes, 8);
    check("o_pwr", {27'b0, pwr}, {27'b0, pwr_expect(1'b0, 0)});

    $display("checks failed: %0d, assertion failures: %0d",
             errors, i_dut.x_seq.x_props.fails);
    if (errors == 0 && i_dut.x_seq.x_props.fails == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// ==== test/pmu_pwr_props.sv ====
// pmu power control properties
// ordering rules for the sequencer outputs, bound into pmu_pwr_seq

module pmu_pwr_props
  import pmu_pkg::*;
(
  input logic     pmu_clk,
  input logic     pad_cpu_rst_b,
  input pwr_ctl_t i_pwr
);

  int unsigned fails = 0;

  // state is saved or restored, never both
  a_save_restore: assert property (@(posedge pmu_clk) disable iff (!pad_cpu_rst_b)
    !(i_pwr.save && i_pwr.restore))
  else
  begin
    $error("save and restore are high together");
    fails++;
  end

  // domain must be isolated whenever it is unpowered
  a_off_isolated: assert property (@(posedge pmu_clk) disable iff (!pad_cpu_rst_b)
    !i_pwr.pwr_on |-> (i_pwr.iso_in && i_pwr.iso_out))
  else
  begin
    $error("power is off while isolation is not fully on");
    fails++;
  end

  a_save_pulse: assert property (@(posedge pmu_clk) disable iff (!pad_cpu_rst_b)
    $rose(i_pwr.save) |=> !i_pwr.save)
  else
  begin
    $error("save pulse is longer than one cycle");
    fails++;
  end

  a_restore_pulse: assert property (@(posedge pmu_clk) disable iff (!pad_cpu_rst_b)
    $rose(i_pwr.restore) |=> !i_pwr.restore)
  else
  begin
    $error("restore pulse is longer than one cycle");
    fails++;
  end

endmodule

bind pmu_pwr_seq pmu_pwr_props x_props (
  .pmu_clk       (pmu_clk),
  .pad_cpu_rst_b (pad_cpu_rst_b),
  .i_pwr         (o_pwr)
);

// ==== rtl/pmu_top.sv ====
// pmu_lite top level
// APB registers, event timer, wakeup logic, sleep FSM and the
// deep sleep power sequencer

module pmu_top
  import pmu_pkg::*;
(
  input  logic              pmu_clk,
  input  logic              pad_cpu_rst_b,
  input  apb_req_t          i_apb,
  output logic [APB_DW-1:0] o_prdata,
  input  logic [1:0]        i_lpmd_b,
  input  logic              i_intraw_vld,
  output logic              o_gate_en0,
  output logic              o_gate_en1,
  output pwr_ctl_t          o_pwr
);

  ctrl_t             ctrl;
  mode_sel_t         mode;
  logic [APB_DW-1:0] load;
  logic [APB_DW-1:0] count;
  logic              evt;
  logic              wakeup;
  logic              mode_normal;
  seq_ctl_t          seq;
  logic              enter_done;
  logic              exit_done;

  pmu_apb_regs x_regs (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_apb         (i_apb),
    .i_count       (count),
    .i_mode_normal (mode_normal),
    .o_prdata      (o_prdata),
    .o_ctrl        (ctrl),
    .o_mode        (mode),
    .o_load        (load)
  );

  pmu_event_timer x_timer (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_counter_en  (ctrl.counter_en),
    .i_load        (load),
    .o_count       (count),
    .o_event       (evt)
  );

  pmu_wake_ctrl x_wake (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_lpmd_b      (i_lpmd_b),
    .i_intraw_vld  (i_intraw_vld),
    .i_ctrl        (ctrl),
    .i_event       (evt),
    .o_wakeup      (wakeup)
  );

  pmu_mode_fsm x_fsm (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_lpmd_b      (i_lpmd_b),
    .i_mode        (mode),
    .i_wakeup      (wakeup),
    .i_enter_done  (enter_done),
    .i_exit_done   (exit_done),
    .o_mode_normal (mode_normal),
    .o_seq         (seq),
    .o_gate_en0    (o_gate_en0),
    .o_gate_en1    (o_gate_en1)
  );

  pmu_pwr_seq x_seq (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_seq         (seq),
    .o_enter_done  (enter_done),
    .o_exit_done   (exit_done),
    .o_pwr         (o_pwr)
  );

endmodule

// ==== rtl/pmu_pwr_seq.sv ====
// pmu deep sleep power sequencer
// a step counter walks the power, isolation, save and restore
// controls through the entry and exit order

module pmu_pwr_seq
  import pmu_pkg::*;
(
  input  logic     pmu_clk,
  input  logic     pad_cpu_rst_b,
  input  seq_ctl_t i_seq,
  output logic     o_enter_done,
  output logic     o_exit_done,
  output pwr_ctl_t o_pwr
);

  logic              seq_en;
  logic [SEQ_CW-1:0] seq_cnt;
  logic              enter_done;
  logic              exit_done;
  pwr_ctl_t          pwr_q;

  //--------------------------------------------------
  // step counter
  //--------------------------------------------------
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      seq_en <= 1'b0;
    else if (i_seq.enter_start || i_seq.exit_start)
      seq_en <= 1'b1;
    else if (enter_done || exit_done)
      seq_en <= 1'b0;
  end

  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      seq_cnt <= '0;
    else if (seq_en)
      seq_cnt <= seq_cnt + 1'b1;
    else
      seq_cnt <= '0;
  end

  //--------------------------------------------------
  // step table
  //--------------------------------------------------
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      pwr_q      <= '{pwr_on: 1'b1, default: 1'b0};
      enter_done <= 1'b0;
      exit_done  <= 1'b0;
    end
    else if (i_seq.in_deep)
    begin
      pwr_q.restore <= 1'b0;
      exit_done     <= 1'b0;
      case (seq_cnt)
        STEP_START:
        begin
          pwr_q.pwr_on  <= 1'b1;
          pwr_q.iso_in  <= 1'b0;
          pwr_q.iso_out <= 1'b0;
        end
        // isolate before anything is saved
        STEP_ISO:
        begin
          pwr_q.iso_in  <= 1'b1;
          pwr_q.iso_out <= 1'b1;
        end
        STEP_SAVE:     pwr_q.save <= 1'b1;
        STEP_SAVE_END: pwr_q.save <= 1'b0;
        STEP_OFF:
        begin
          pwr_q.pwr_on <= 1'b0;
          enter_done   <= 1'b1;
        end
        default: ;
      endcase
    end
    else if (i_seq.in_exit)
    begin
      pwr_q.save <= 1'b0;
      enter_done <= 1'b0;
      // single cycle restore pulse
      pwr_q.restore <= (seq_cnt == STEP_ISO);
      case (seq_cnt)
        STEP_START: pwr_q.pwr_on <= 1'b1;
        STEP_SAVE:
        begin
          pwr_q.iso_in  <= 1'b0;
          pwr_q.iso_out <= 1'b0;
        end
        STEP_OFF: exit_done <= 1'b1;
        default: ;
      endcase
    end
  end

  assign o_enter_done = enter_done;
  assign o_exit_done  = exit_done;
  assign o_pwr        = pwr_q;

endmodule

// ==== rtl/pmu_mode_fsm.sv ====
// pmu sleep mode FSM
// picks light or deep sleep from the mode flags, drives the clock
// gates and starts the deep sleep power sequencer

module pmu_mode_fsm
  import pmu_pkg::*;
(
  input  logic       pmu_clk,
  input  logic       pad_cpu_rst_b,
  input  logic [1:0] i_lpmd_b,
  input  mode_sel_t  i_mode,
  input  logic       i_wakeup,
  input  logic       i_enter_done,
  input  logic       i_exit_done,
  output logic       o_mode_normal,
  output seq_ctl_t   o_seq,
  output logic       o_gate_en0,
  output logic       o_gate_en1
);

  pmu_state_t state_q;
  pmu_state_t state_d;
  logic       run_req;
  logic       enter_q;
  logic       exit_q;

  assign run_req = (i_lpmd_b == LPMD_RUN);

  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      state_q <= NORMAL;
    else
      state_q <= state_d;
  end

  //--------------------------------------------------
  // next state
  //--------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      NORMAL:
      begin
        // normal flag pins the core awake, light wins over deep
        if (!i_mode.normal && !run_req)
        begin
          if (i_mode.clk_slow || i_mode.clk_off)
            state_d = LIGHT_SLP;
          else if (i_mode.ret_pwr_off || i_mode.pwr_off)
            state_d = DEEP_SLP;
        end
      end
      LIGHT_SLP:
        if (i_wakeup)
          state_d = LSLP_TO_NORMAL;
      LSLP_TO_NORMAL:
        if (run_req)
          state_d = NORMAL;
      // leave only once power is fully down
      DEEP_SLP:
        if (i_wakeup && i_enter_done)
          state_d = DSLP_TO_NORMAL;
      DSLP_TO_NORMAL:
        if (run_req && i_exit_done)
          state_d = NORMAL;
      default: state_d = NORMAL;
    endcase
  end

  // one-cycle sequencer start strobes
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      enter_q <= 1'b0;
      exit_q  <= 1'b0;
    end
    else
    begin
      enter_q <= (state_q == NORMAL) && (state_d == DEEP_SLP);
      exit_q  <= (state_q == DEEP_SLP) && (state_d == DSLP_TO_NORMAL);
    end
  end

  assign o_seq = '{enter_start: enter_q,
                   exit_start:  exit_q,
                   in_deep:     (state_q == DEEP_SLP),
                   in_exit:     (state_q == DSLP_TO_NORMAL)};

  assign o_mode_normal = (state_q == NORMAL);

  // gate_en0 slows the clock, gate_en1 stops it
  assign o_gate_en0 = (state_q == LIGHT_SLP) && i_mode.clk_slow;
  assign o_gate_en1 = ((state_q == LIGHT_SLP) && i_mode.clk_off) ||
                      ((state_q == DEEP_SLP) && i_mode.ret_pwr_off);

endmodule

// ==== rtl/pmu_wake_ctrl.sv ====
// pmu wakeup control
// catches timer events while asleep and merges them with the interrupt wakeup

module pmu_wake_ctrl
  import pmu_pkg::*;
(
  input  logic       pmu_clk,
  input  logic       pad_cpu_rst_b,
  input  logic [1:0] i_lpmd_b,
  input  logic       i_intraw_vld,
  input  ctrl_t      i_ctrl,
  input  logic       i_event,
  output logic       o_wakeup
);

  logic sleep_req;
  logic event_q;
  logic event_rise;
  logic event_pend;

  assign sleep_req = (i_lpmd_b != LPMD_RUN);

  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      event_q <= 1'b0;
    else
      event_q <= i_event;
  end

  // only events seen during a sleep request count
  assign event_rise = i_event && !event_q && sleep_req;

  // sticky until the core runs again
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      event_pend <= 1'b0;
    else if (event_rise)
      event_pend <= 1'b1;
    else if (!sleep_req)
      event_pend <= 1'b0;
  end

  assign o_wakeup = (event_pend && i_ctrl.event_en) ||
                    (i_intraw_vld && i_ctrl.wic_en && sleep_req);

endmodule

// ==== rtl/pmu_event_timer.sv ====
// pmu event timer
// reloading down-counter, raises a periodic event while the count is zero

module pmu_event_timer
  import pmu_pkg::*;
(
  input  logic              pmu_clk,
  input  logic              pad_cpu_rst_b,
  input  logic              i_counter_en,
  input  logic [APB_DW-1:0] i_load,
  output logic [APB_DW-1:0] o_count,
  output logic              o_event
);

  logic              en_q;
  logic              load_en;
  logic [APB_DW-1:0] count_q;

  // enable edge detect
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      en_q <= 1'b0;
    else
      en_q <= i_counter_en;
  end

  // reload on a fresh enable or once the count runs out
  assign load_en = (i_counter_en && !en_q) || (count_q == '0);

  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      count_q <= '0;
    else if (load_en)
      count_q <= i_load;
    else if (i_counter_en)
      count_q <= count_q - 1'b1;
  end

  assign o_count = count_q;
  assign o_event = (count_q == '0) && i_counter_en;

endmodule

// ==== rtl/pmu_apb_regs.sv ====
// pmu APB register block
// control, counter load and low-power mode registers with a
// zero-wait-state write port and a combinational read path

module pmu_apb_regs
  import pmu_pkg::*;
(
  input  logic              pmu_clk,
  input  logic              pad_cpu_rst_b,
  input  apb_req_t          i_apb,
  input  logic [APB_DW-1:0] i_count,
  input  logic              i_mode_normal,
  output logic [APB_DW-1:0] o_prdata,
  output ctrl_t             o_ctrl,
  output mode_sel_t         o_mode,
  output logic [APB_DW-1:0] o_load
);

  localparam int CTRL_W = $bits(ctrl_t);
  localparam int MODE_W = $bits(mode_sel_t);

  logic              wr_en;
  logic              rd_en;
  ctrl_t             ctrl_q;
  logic [APB_DW-1:0] load_q;
  logic [APB_DW-1:0] mode_q;

  assign wr_en = i_apb.psel && i_apb.pwrite && i_apb.penable;
  assign rd_en = i_apb.psel && !i_apb.pwrite;

  //--------------------------------------------------
  // register writes
  //--------------------------------------------------
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      ctrl_q <= '0;
      load_q <= '0;
      mode_q <= '0;
    end
    else if (wr_en)
    begin
      case (i_apb.paddr)
        ADDR_CTRL: ctrl_q <= ctrl_t'(i_apb.pwdata[CTRL_W-1:0]);
        ADDR_LOAD: load_q <= i_apb.pwdata;
        // strategy may only change while the core is running
        ADDR_MODE:
        begin
          if (i_mode_normal)
            mode_q <= i_apb.pwdata;
        end
        default: ;
      endcase
    end
  end

  //--------------------------------------------------
  // read path, zero when no read is in progress
  //--------------------------------------------------
  always_comb
  begin
    o_prdata = '0;
    if (rd_en)
    begin
      case (i_apb.paddr)
        ADDR_CTRL: o_prdata = {{(APB_DW-CTRL_W){1'b0}}, ctrl_q};
        // live counter value, not the load value
        ADDR_LOAD: o_prdata = i_count;
        ADDR_MODE: o_prdata = mode_q;
        default:   o_prdata = '0;
      endcase
    end
  end

  assign o_ctrl = ctrl_q;
  assign o_mode = mode_sel_t'(mode_q[MODE_W-1:0]);
  assign o_load = load_q;

endmodule

// ==== rtl/pmu_pkg.sv ====
// pmu_lite shared definitions
// register map, sequencer step table, FSM state type and the
// structs that carry the APB request, control fields and power controls

package pmu_pkg;

  //--------------------------------------------------
  // APB register map
  //--------------------------------------------------
  localparam int APB_AW = 12;
  localparam int APB_DW = 32;

  localparam logic [APB_AW-1:0] ADDR_CTRL = 12'h000;
  localparam logic [APB_AW-1:0] ADDR_LOAD = 12'h004;
  localparam logic [APB_AW-1:0] ADDR_MODE = 12'h008;

  // core low-power code for run, anything else asks for sleep
  localparam logic [1:0] LPMD_RUN = 2'b11;

  //--------------------------------------------------
  // deep sleep sequencer steps
  //--------------------------------------------------
  localparam int SEQ_CW = 16;

  localparam logic [SEQ_CW-1:0] STEP_START    = 16'h0001;
  localparam logic [SEQ_CW-1:0] STEP_ISO      = 16'h0020;
  localparam logic [SEQ_CW-1:0] STEP_SAVE     = 16'h0040;
  localparam logic [SEQ_CW-1:0] STEP_SAVE_END = 16'h0041;
  localparam logic [SEQ_CW-1:0] STEP_OFF      = 16'h0060;

  typedef enum logic [2:0] {
    NORMAL         = 3'd0,
    LIGHT_SLP      = 3'd1,
    LSLP_TO_NORMAL = 3'd2,
    DEEP_SLP       = 3'd3,
    DSLP_TO_NORMAL = 3'd4
  } pmu_state_t;

  // control register, bit 0 first from the bottom
  typedef struct packed {
    logic counter_en;
    logic rsvd;
    logic event_en;
    logic wic_en;
  } ctrl_t;

  // low-power strategy flags
  typedef struct packed {
    logic pwr_off;
    logic ret_pwr_off;
    logic clk_off;
    logic clk_slow;
    logic normal;
  } mode_sel_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic pwr_on;
    logic iso_in;
    logic iso_out;
    logic save;
    logic restore;
  } pwr_ctl_t;

  // FSM to sequencer
  typedef struct packed {
    logic enter_start;
    logic exit_start;
    logic in_deep;
    logic in_exit;
  } seq_ctl_t;

endpackage
